//--- hdl/lsqPkg.sv
// load/store queue geometry
package lsqPkg;

  // queue shape, shared by dispatch, execute and commit
  localparam int LSQ_DEPTH = 8;  // entries per queue
  localparam int LSQ_ID_W  = 3;  // log2 of depth

  // entry index into either queue
  // wraps naturally since depth is a power of two
  typedef logic [LSQ_ID_W-1:0] lsqIdT;

  // occupancy, one bit wider so a full queue (8) fits
  typedef logic [LSQ_ID_W:0] lsqCountT;

endpackage

//--- hdl/memPkg.sv
// memory port types
package memPkg;

  localparam int MEM_ADDR_W = 16;  // word address, no byte offset
  localparam int MEM_DATA_W = 32;  // full word accesses only

  typedef logic [MEM_ADDR_W-1:0] memAddrT;
  typedef logic [MEM_DATA_W-1:0] memDataT;

  // four-phase req/ack handshake, requester side
  typedef enum logic [1:0] {
    PORT_IDLE,     // no request, ack seen low
    PORT_REQ,      // req high, waiting for ack high
    PORT_RELEASE   // req dropped, waiting for ack low
  } memPortStateE;

endpackage

//--- hdl/lsqAlloc.sv
// load/store queue allocation
`timescale 1ns/1ps

module lsqAlloc
  import lsqPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     dispatchValid_i,
  input  logic     dispatchIsStore_i,
  input  logic     commitLoad_i,
  input  logic     stFree_i,          // head store reached memory
  output logic     dispatchReady_o,
  output lsqIdT    dispatchId_o,
  output lsqCountT ldqCount_o,
  output lsqCountT stqCount_o,
  output lsqIdT    sqHead_o,
  output lsqIdT    sqTail_o,
  output logic     ldAlloc_o,
  output logic     stAlloc_o
);

  // load queue keeps no entry state here, so its head is implicit in the count
  lsqIdT    ldTail;
  lsqCountT ldCount;
  lsqIdT    sqHead;
  lsqIdT    sqTail;
  lsqCountT sqCount;
  logic     ldFree;

  // ready only looks at the queue being targeted
  assign dispatchReady_o = dispatchIsStore_i ? (sqCount != lsqCountT'(LSQ_DEPTH))
                                             : (ldCount != lsqCountT'(LSQ_DEPTH));
  assign dispatchId_o    = dispatchIsStore_i ? sqTail : ldTail;  // tail goes out same cycle

  assign ldAlloc_o = dispatchValid_i & dispatchReady_o & ~dispatchIsStore_i;
  assign stAlloc_o = dispatchValid_i & dispatchReady_o & dispatchIsStore_i;
  assign ldFree    = commitLoad_i & (ldCount != '0);  // ignore commit on empty queue

  assign ldqCount_o = ldCount;
  assign stqCount_o = sqCount;
  assign sqHead_o   = sqHead;
  assign sqTail_o   = sqTail;  // becomes the boundary of a dispatching load

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ldTail  <= '0;
      ldCount <= '0;
      sqHead  <= '0;
      sqTail  <= '0;
      sqCount <= '0;
    end
    else
    begin
      if (ldAlloc_o)
      begin
        ldTail <= ldTail + lsqIdT'(1);  // modulo depth
      end
      if (stAlloc_o)
      begin
        sqTail <= sqTail + lsqIdT'(1);
      end
      if (stFree_i)
      begin
        sqHead <= sqHead + lsqIdT'(1);  // oldest store retired to memory
      end

      // load occupancy, alloc and free may land together
      case ({ldAlloc_o, ldFree})
        2'b10:   ldCount <= ldCount + lsqCountT'(1);
        2'b01:   ldCount <= ldCount - lsqCountT'(1);
        default: ldCount <= ldCount;
      endcase

      // store occupancy
      case ({stAlloc_o, stFree_i})
        2'b10:   sqCount <= sqCount + lsqCountT'(1);
        2'b01:   sqCount <= sqCount - lsqCountT'(1);
        default: sqCount <= sqCount;
      endcase
    end
  end

endmodule

//--- hdl/storeQueue.sv
// store queue with forwarding search
`timescale 1ns/1ps

module storeQueue
  import lsqPkg::*;
  import memPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    stAlloc_i,      // dispatch strobe for a store
  input  lsqIdT   allocId_i,
  input  lsqIdT   sqHead_i,
  input  logic    stWrite_i,      // store address/data from AGEN
  input  lsqIdT   stWriteId_i,
  input  memAddrT stWriteAddr_i,
  input  memDataT stWriteData_i,
  input  memAddrT searchAddr_i,   // load address
  input  lsqIdT   searchBound_i,  // first store younger than the load
  output logic    fwdHit_o,
  output memDataT fwdData_o,
  output memAddrT headAddr_o,
  output memDataT headData_o
);

  memAddrT                addrMem [LSQ_DEPTH];
  memDataT                dataMem [LSQ_DEPTH];
  logic [LSQ_DEPTH-1:0]   addrValid;  // address known

  lsqIdT winLen;  // number of stores older than the load
  lsqIdT scanIdx;
  lsqIdT fwdIdx;

  // commit side always reads the oldest store
  assign headAddr_o = addrMem[sqHead_i];
  assign headData_o = dataMem[sqHead_i];

  // valid bits are control state
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      addrValid <= '0;
    end
    else
    begin
      if (stAlloc_i)
      begin
        addrValid[allocId_i] <= 1'b0;  // new store, address not yet known
      end
      if (stWrite_i)
      begin
        addrValid[stWriteId_i] <= 1'b1;
      end
    end
  end

  // address and data storage
  always_ff @(posedge clk)
  begin
    if (stWrite_i)
    begin
      addrMem[stWriteId_i] <= stWriteAddr_i;
      dataMem[stWriteId_i] <= stWriteData_i;
    end
  end

  // CAM search over the window head..bound-1
  // scan oldest to youngest so the last match is the youngest older store
  // note: a load dispatched into a full store queue sees bound == head,
  // which reads as an empty window
  always_comb
  begin
    winLen   = searchBound_i - sqHead_i;  // modulo depth
    fwdHit_o = 1'b0;
    fwdIdx   = sqHead_i;
    scanIdx  = sqHead_i;
    for (int k = 0; k < LSQ_DEPTH; k++)
    begin
      scanIdx = sqHead_i + lsqIdT'(k);
      if ((lsqIdT'(k) < winLen) && addrValid[scanIdx]
          && (addrMem[scanIdx] == searchAddr_i))
      begin
        fwdHit_o = 1'b1;
        fwdIdx   = scanIdx;  // younger match overrides
      end
    end
  end

  assign fwdData_o = dataMem[fwdIdx];  // data RAM read on the winner

endmodule

//--- hdl/loadExecute.sv
// load execute and read port
`timescale 1ns/1ps

module loadExecute
  import lsqPkg::*;
  import memPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    ldAlloc_i,       // load dispatch strobe
  input  lsqIdT   allocId_i,
  input  lsqIdT   sqTail_i,        // store boundary at dispatch
  input  logic    agenValid_i,
  input  logic    agenIsStore_i,
  input  lsqIdT   agenId_i,
  input  memAddrT agenAddr_i,
  input  logic    fwdHit_i,
  input  memDataT fwdData_i,
  input  logic    ldAck_i,
  input  memDataT ldData_i,
  output logic    agenReady_o,
  output logic    stWrite_o,
  output memAddrT searchAddr_o,
  output lsqIdT   searchBound_o,
  output logic    ldReq_o,
  output memAddrT ldAddr_o,
  output logic    wbValid_o,
  output lsqIdT   wbId_o,
  output memDataT wbData_o,
  output logic    wbForwarded_o
);

  lsqIdT        bndMem [LSQ_DEPTH];  // per-load store boundary
  memPortStateE portState;
  lsqIdT        ldId;
  memAddrT      ldAddrQ;
  logic         agenAccept;
  logic         ldAccept;

  // one load in flight, stores stall behind it too
  assign agenReady_o = (portState == PORT_IDLE) & ~(wbValid_o & wbForwarded_o);
  assign agenAccept  = agenValid_i & agenReady_o;
  assign ldAccept    = agenAccept & ~agenIsStore_i;
  assign stWrite_o   = agenAccept & agenIsStore_i;  // straight into the store queue

  // search runs combinationally in the accepting cycle
  assign searchAddr_o  = agenAddr_i;
  assign searchBound_o = bndMem[agenId_i];

  assign ldReq_o  = (portState == PORT_REQ);
  assign ldAddr_o = ldAddrQ;  // held stable for the whole handshake
  assign wbId_o   = ldId;

  // boundary table and load payload
  always_ff @(posedge clk)
  begin
    if (ldAlloc_i)
    begin
      bndMem[allocId_i] <= sqTail_i;
    end
    if (ldAccept)
    begin
      ldId          <= agenId_i;
      ldAddrQ       <= agenAddr_i;
      wbData_o      <= fwdData_i;  // used only on a hit
      wbForwarded_o <= fwdHit_i;
    end
    else if ((portState == PORT_REQ) && ldAck_i)
    begin
      wbData_o <= ldData_i;  // read data valid with ack
    end
  end

  // read handshake and writeback pulse
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      portState <= PORT_IDLE;
      wbValid_o <= 1'b0;
    end
    else
    begin
      wbValid_o <= 1'b0;  // single cycle
      case (portState)
        PORT_IDLE:
        begin
          if (ldAccept && fwdHit_i)
          begin
            wbValid_o <= 1'b1;  // forwarded, no memory access
          end
          else if (ldAccept)
          begin
            portState <= PORT_REQ;
          end
        end
        PORT_REQ:
        begin
          if (ldAck_i)
          begin
            portState <= PORT_RELEASE;
            wbValid_o <= 1'b1;
          end
        end
        PORT_RELEASE:
        begin
          if (!ldAck_i)
          begin
            portState <= PORT_IDLE;  // ack low, port free again
          end
        end
        default: portState <= PORT_IDLE;
      endcase
    end
  end

endmodule

//--- hdl/storeCommit.sv
// store commit write port
`timescale 1ns/1ps

module storeCommit
  import memPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    commitStore_i,
  input  memAddrT headAddr_i,      // oldest store in the queue
  input  memDataT headData_i,
  input  logic    stAck_i,
  output logic    stCommitReady_o,
  output logic    stReq_o,
  output memAddrT stAddr_o,
  output memDataT stData_o,
  output logic    stFree_o        // retire the head entry
);

  memPortStateE portState;
  logic         commitAccept;

  // one store write at a time keeps memory order equal to program order
  assign stCommitReady_o = (portState == PORT_IDLE);
  assign commitAccept    = commitStore_i & stCommitReady_o;
  assign stReq_o         = (portState == PORT_REQ);

  // head advances on the same edge the port goes idle,
  // so the next commit already sees the new head
  assign stFree_o = (portState == PORT_RELEASE) & ~stAck_i;

  // address/data latched once, stable while req is high
  always_ff @(posedge clk)
  begin
    if (commitAccept)
    begin
      stAddr_o <= headAddr_i;
      stData_o <= headData_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      portState <= PORT_IDLE;
    end
    else
    begin
      case (portState)
        PORT_IDLE:
        begin
          if (commitAccept)
          begin
            portState <= PORT_REQ;
          end
        end
        PORT_REQ:
        begin
          if (stAck_i)
          begin
            portState <= PORT_RELEASE;  // write taken, drop req
          end
        end
        PORT_RELEASE:
        begin
          if (!stAck_i)
          begin
            portState <= PORT_IDLE;
          end
        end
        default: portState <= PORT_IDLE;
      endcase
    end
  end

endmodule

//--- hdl/lsuTop.sv
// load-store unit top
`timescale 1ns/1ps

module lsuTop
  import lsqPkg::*;
  import memPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     dispatchValid_i,
  input  logic     dispatchIsStore_i,
  output logic     dispatchReady_o,
  output lsqIdT    dispatchId_o,
  output lsqCountT ldqCount_o,
  output lsqCountT stqCount_o,
  input  logic     agenValid_i,
  input  logic     agenIsStore_i,
  input  lsqIdT    agenId_i,
  input  memAddrT  agenAddr_i,
  input  memDataT  agenData_i,
  output logic     agenReady_o,
  output logic     wbValid_o,
  output lsqIdT    wbId_o,
  output memDataT  wbData_o,
  output logic     wbForwarded_o,
  input  logic     commitLoad_i,
  input  logic     commitStore_i,
  output logic     stCommitReady_o,
  output logic     ldReq_o,
  output memAddrT  ldAddr_o,
  input  logic     ldAck_i,
  input  memDataT  ldData_i,
  output logic     stReq_o,
  output memAddrT  stAddr_o,
  output memDataT  stData_o,
  input  logic     stAck_i
);

  lsqIdT   sqHead;
  lsqIdT   sqTail;
  logic    ldAlloc;
  logic    stAlloc;
  logic    stFree;       // commit -> dispatch
  logic    stWrite;      // execute -> store queue
  memAddrT searchAddr;
  lsqIdT   searchBound;
  logic    fwdHit;
  memDataT fwdData;
  memAddrT headAddr;     // store queue -> commit
  memDataT headData;

  // dispatch stage
  lsqAlloc uAlloc (
    .clk               (clk),
    .reset             (reset),
    .dispatchValid_i   (dispatchValid_i),
    .dispatchIsStore_i (dispatchIsStore_i),
    .commitLoad_i      (commitLoad_i),
    .stFree_i          (stFree),
    .dispatchReady_o   (dispatchReady_o),
    .dispatchId_o      (dispatchId_o),
    .ldqCount_o        (ldqCount_o),
    .stqCount_o        (stqCount_o),
    .sqHead_o          (sqHead),
    .sqTail_o          (sqTail),
    .ldAlloc_o         (ldAlloc),
    .stAlloc_o         (stAlloc)
  );

  // store storage, shared by execute and commit
  storeQueue uStoreQ (
    .clk           (clk),
    .reset         (reset),
    .stAlloc_i     (stAlloc),
    .allocId_i     (dispatchId_o),
    .sqHead_i      (sqHead),
    .stWrite_i     (stWrite),
    .stWriteId_i   (agenId_i),     // AGEN packet fields go straight in
    .stWriteAddr_i (agenAddr_i),
    .stWriteData_i (agenData_i),
    .searchAddr_i  (searchAddr),
    .searchBound_i (searchBound),
    .fwdHit_o      (fwdHit),
    .fwdData_o     (fwdData),
    .headAddr_o    (headAddr),
    .headData_o    (headData)
  );

  // execute stage
  loadExecute uLoadEx (
    .clk           (clk),
    .reset         (reset),
    .ldAlloc_i     (ldAlloc),
    .allocId_i     (dispatchId_o),
    .sqTail_i      (sqTail),
    .agenValid_i   (agenValid_i),
    .agenIsStore_i (agenIsStore_i),
    .agenId_i      (agenId_i),
    .agenAddr_i    (agenAddr_i),
    .fwdHit_i      (fwdHit),
    .fwdData_i     (fwdData),
    .ldAck_i       (ldAck_i),
    .ldData_i      (ldData_i),
    .agenReady_o   (agenReady_o),
    .stWrite_o     (stWrite),
    .searchAddr_o  (searchAddr),
    .searchBound_o (searchBound),
    .ldReq_o       (ldReq_o),
    .ldAddr_o      (ldAddr_o),
    .wbValid_o     (wbValid_o),
    .wbId_o        (wbId_o),
    .wbData_o      (wbData_o),
    .wbForwarded_o (wbForwarded_o)
  );

  // commit stage
  storeCommit uStCommit (
    .clk             (clk),
    .reset           (reset),
    .commitStore_i   (commitStore_i),
    .headAddr_i      (headAddr),
    .headData_i      (headData),
    .stAck_i         (stAck_i),
    .stCommitReady_o (stCommitReady_o),
    .stReq_o         (stReq_o),
    .stAddr_o        (stAddr_o),
    .stData_o        (stData_o),
    .stFree_o        (stFree)
  );

endmodule

//--- tests/memResponder.sv
// word memory model for both ports
`timescale 1ns/1ps

module memResponder
  import memPkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    ldReq_i,
  input  memAddrT ldAddr_i,
  output logic    ldAck_o,
  output memDataT ldData_o,         // valid with ack
  input  logic    stReq_i,
  input  memAddrT stAddr_i,
  input  memDataT stData_i,
  output logic    stAck_o,
  output logic    protocolError_o   // sticky, top stops the run
);

  memDataT     mem [64];
  logic [31:0] rngState;
  int          ldWait;      // cycles left before ack
  int          stWait;
  logic        ldBusy;      // request seen, ack not yet dropped
  logic        stBusy;
  memAddrT     ldAddrSeen;  // address captured when req rose
  memAddrT     stAddrSeen;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  always @(posedge clk)
  begin
    if (reset)
    begin
      for (int a = 0; a < 64; a++)
      begin
        mem[a] <= a * 32'h0001_0001;  // word a holds a in both halves
      end
      rngState        = 32'd84473;
      ldAck_o         <= 1'b0;
      stAck_o         <= 1'b0;
      ldData_o        <= '0;
      ldBusy          <= 1'b0;
      stBusy          <= 1'b0;
      ldWait          <= 0;
      stWait          <= 0;
      protocolError_o <= 1'b0;
    end
    else
    begin
      // load port
      if (ldAck_o)
      begin
        if (!ldReq_i)
        begin
          ldAck_o <= 1'b0;  // phase 4
          ldBusy  <= 1'b0;
        end
      end
      else if (ldBusy)
      begin
        if (!ldReq_i)
        begin
          $display("memResponder: load request dropped before ack at %0t", $time);
          protocolError_o <= 1'b1;
        end
        else if (ldWait == 0)
        begin
          ldAck_o  <= 1'b1;
          ldData_o <= mem[ldAddrSeen[5:0]];
        end
        else
        begin
          ldWait <= ldWait - 1;
        end
      end
      else if (ldReq_i)
      begin
        rngState = xorshift32(rngState);
        ldBusy     <= 1'b1;
        ldAddrSeen <= ldAddr_i;
        ldWait     <= int'(rngState[1:0]);  // 0..3 cycles
      end
      if (ldBusy && ldReq_i && (ldAddr_i != ldAddrSeen))
      begin
        $display("memResponder: load address changed while req was high at %0t", $time);
        protocolError_o <= 1'b1;
      end

      // store port, same handshake
      if (stAck_o)
      begin
        if (!stReq_i)
        begin
          stAck_o <= 1'b0;
          stBusy  <= 1'b0;
        end
      end
      else if (stBusy)
      begin
        if (!stReq_i)
        begin
          $display("memResponder: store request dropped before ack at %0t", $time);
          protocolError_o <= 1'b1;
        end
        else if (stWait == 0)
        begin
          stAck_o                 <= 1'b1;
          mem[stAddrSeen[5:0]]    <= stData_i;  // write lands with ack
        end
        else
        begin
          stWait <= stWait - 1;
        end
      end
      else if (stReq_i)
      begin
        rngState = xorshift32(rngState);
        stBusy     <= 1'b1;
        stAddrSeen <= stAddr_i;
        stWait     <= int'(rngState[1:0]);
      end
      if (stBusy && stReq_i && (stAddr_i != stAddrSeen))
      begin
        $display("memResponder: store address changed while req was high at %0t", $time);
        protocolError_o <= 1'b1;
      end
    end
  end

endmodule

//--- tests/lsuTb.sv
// load-store unit testbench
`timescale 1ns/1ps

module lsuTb
  import lsqPkg::*;
  import memPkg::*;
();

  typedef enum logic [2:0] {
    OP_DISPATCH,
    OP_FULL,       // store dispatch must be refused
    OP_AGEN_ST,
    OP_AGEN_LD,
    OP_COMMIT_LD,
    OP_COMMIT_ST
  } opKindE;

  typedef struct packed {
    opKindE   kind;
    logic     isStore;  // dispatch target queue
    lsqIdT    id;       // expected dispatch id, or AGEN id
    memAddrT  addr;
    memDataT  data;     // store data, or expected load data
    logic     fwd;      // expected forwarded flag
    lsqCountT cnt;      // queue occupancy after the op
  } opRowT;

  opRowT opTable[$];
  int    cycleCount = 0;
  int    cycleLimit = 0;

  logic     clk;
  logic     reset;
  logic     dispatchValid;
  logic     dispatchIsStore;
  logic     dispatchReady;
  lsqIdT    dispatchId;
  lsqCountT ldqCount;
  lsqCountT stqCount;
  logic     agenValid;
  logic     agenIsStore;
  lsqIdT    agenId;
  memAddrT  agenAddr;
  memDataT  agenData;
  logic     agenReady;
  logic     wbValid;
  lsqIdT    wbId;
  memDataT  wbData;
  logic     wbForwarded;
  logic     commitLoad;
  logic     commitStore;
  logic     stCommitReady;
  logic     ldReq;
  memAddrT  ldAddr;
  logic     ldAck;
  memDataT  ldData;
  logic     stReq;
  memAddrT  stAddr;
  memDataT  stData;
  logic     stAck;
  logic     protocolError;

  lsuTop DUT (
    .clk               (clk),
    .reset             (reset),
    .dispatchValid_i   (dispatchValid),
    .dispatchIsStore_i (dispatchIsStore),
    .dispatchReady_o   (dispatchReady),
    .dispatchId_o      (dispatchId),
    .ldqCount_o        (ldqCount),
    .stqCount_o        (stqCount),
    .agenValid_i       (agenValid),
    .agenIsStore_i     (agenIsStore),
    .agenId_i          (agenId),
    .agenAddr_i        (agenAddr),
    .agenData_i        (agenData),
    .agenReady_o       (agenReady),
    .wbValid_o         (wbValid),
    .wbId_o            (wbId),
    .wbData_o          (wbData),
    .wbForwarded_o     (wbForwarded),
    .commitLoad_i      (commitLoad),
    .commitStore_i     (commitStore),
    .stCommitReady_o   (stCommitReady),
    .ldReq_o           (ldReq),
    .ldAddr_o          (ldAddr),
    .ldAck_i           (ldAck),
    .ldData_i          (ldData),
    .stReq_o           (stReq),
    .stAddr_o          (stAddr),
    .stData_o          (stData),
    .stAck_i           (stAck)
  );

  memResponder uMem (
    .clk             (clk),
    .reset           (reset),
    .ldReq_i         (ldReq),
    .ldAddr_i        (ldAddr),
    .ldAck_o         (ldAck),
    .ldData_o        (ldData),
    .stReq_i         (stReq),
    .stAddr_i        (stAddr),
    .stData_i        (stData),
    .stAck_o         (stAck),
    .protocolError_o (protocolError)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic checkId(input string what, input lsqIdT got, input lsqIdT exp);
    if (got !== exp)
    begin
      abortRun($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic checkCount(input string what, input lsqCountT got, input lsqCountT exp);
    if (got !== exp)
    begin
      abortRun($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic checkData(input string what, input memDataT got, input memDataT exp);
    if (got !== exp)
    begin
      abortRun($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic checkFlag(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      abortRun($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // cycle budget and memory protocol watch
  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount >= cycleLimit)
    begin
      abortRun($sformatf("timeout: run did not finish within %0d cycles", cycleLimit));
    end
    else if (protocolError)
    begin
      abortRun("memory model saw a broken four-phase handshake");
    end
  end

  function automatic void addRow(input opKindE kind, input logic isStore, input lsqIdT id,
                                 input memAddrT addr, input memDataT data, input logic fwd,
                                 input lsqCountT cnt);
    opTable.push_back(opRowT'{kind, isStore, id, addr, data, fwd, cnt});
  endfunction

  function automatic void buildTable();
    memAddrT missAddrs [6];
    memDataT missData [6];
    missAddrs = '{16'd40, 16'd41, 16'd17, 16'd26, 16'd35, 16'd63};
    // 40 and 41 hold committed store data
    // the rest still hold the fill pattern
    missData  = '{32'hDDDD3333, 32'hEEEE4444, 32'h00110011, 32'h001A001A,
                  32'h00230023, 32'h003F003F};
    // two older stores, two loads, one younger store
    addRow(OP_DISPATCH,  1'b1, 3'd0, 16'd0,  32'h0,        1'b0, 4'd1);
    addRow(OP_DISPATCH,  1'b1, 3'd1, 16'd0,  32'h0,        1'b0, 4'd2);
    addRow(OP_DISPATCH,  1'b0, 3'd0, 16'd0,  32'h0,        1'b0, 4'd1);
    addRow(OP_DISPATCH,  1'b0, 3'd1, 16'd0,  32'h0,        1'b0, 4'd2);
    addRow(OP_DISPATCH,  1'b1, 3'd2, 16'd0,  32'h0,        1'b0, 4'd3);
    addRow(OP_AGEN_ST,   1'b1, 3'd0, 16'd5,  32'hAAAA0000, 1'b0, 4'd0);
    addRow(OP_AGEN_ST,   1'b1, 3'd1, 16'd5,  32'hBBBB1111, 1'b0, 4'd0);
    addRow(OP_AGEN_ST,   1'b1, 3'd2, 16'd9,  32'hCCCC2222, 1'b0, 4'd0);
    addRow(OP_AGEN_LD,   1'b0, 3'd0, 16'd5,  32'hBBBB1111, 1'b1, 4'd0);  // younger of two
    addRow(OP_AGEN_LD,   1'b0, 3'd1, 16'd9,  32'h00090009, 1'b0, 4'd0);  // match only younger
    addRow(OP_DISPATCH,  1'b0, 3'd2, 16'd0,  32'h0,        1'b0, 4'd3);
    addRow(OP_AGEN_LD,   1'b0, 3'd2, 16'd12, 32'h000C000C, 1'b0, 4'd0);  // no match
    addRow(OP_COMMIT_LD, 1'b0, 3'd0, 16'd0,  32'h0,        1'b0, 4'd2);
    addRow(OP_COMMIT_LD, 1'b0, 3'd0, 16'd0,  32'h0,        1'b0, 4'd1);
    addRow(OP_COMMIT_LD, 1'b0, 3'd0, 16'd0,  32'h0,        1'b0, 4'd0);
    // committed stores reach memory in order
    addRow(OP_COMMIT_ST, 1'b1, 3'd0, 16'd0,  32'h0,        1'b0, 4'd2);
    addRow(OP_COMMIT_ST, 1'b1, 3'd0, 16'd0,  32'h0,        1'b0, 4'd1);
    addRow(OP_DISPATCH,  1'b0, 3'd3, 16'd0,  32'h0,        1'b0, 4'd1);
    addRow(OP_AGEN_LD,   1'b0, 3'd3, 16'd5,  32'hBBBB1111, 1'b0, 4'd0);
    addRow(OP_COMMIT_ST, 1'b1, 3'd0, 16'd0,  32'h0,        1'b0, 4'd0);
    addRow(OP_DISPATCH,  1'b0, 3'd4, 16'd0,  32'h0,        1'b0, 4'd2);
    addRow(OP_AGEN_LD,   1'b0, 3'd4, 16'd9,  32'hCCCC2222, 1'b0, 4'd0);
    addRow(OP_COMMIT_LD, 1'b0, 3'd0, 16'd0,  32'h0,        1'b0, 4'd1);
    addRow(OP_COMMIT_LD, 1'b0, 3'd0, 16'd0,  32'h0,        1'b0, 4'd0);
    // fill the store queue so ids wrap past 7
    for (int k = 0; k < 8; k++)
    begin
      addRow(OP_DISPATCH, 1'b1, lsqIdT'(3 + k), 16'd0, 32'h0, 1'b0, lsqCountT'(k + 1));
    end
    addRow(OP_FULL,      1'b1, 3'd0, 16'd0,  32'h0,        1'b0, 4'd8);
    addRow(OP_AGEN_ST,   1'b1, 3'd3, 16'd40, 32'hDDDD3333, 1'b0, 4'd0);
    addRow(OP_AGEN_ST,   1'b1, 3'd4, 16'd41, 32'hEEEE4444, 1'b0, 4'd0);
    addRow(OP_COMMIT_ST, 1'b1, 3'd0, 16'd0,  32'h0,        1'b0, 4'd7);
    addRow(OP_COMMIT_ST, 1'b1, 3'd0, 16'd0,  32'h0,        1'b0, 4'd6);
    // load misses under random ack delay with wrapping load ids
    for (int k = 0; k < 6; k++)
    begin
      addRow(OP_DISPATCH, 1'b0, lsqIdT'(5 + k), 16'd0, 32'h0, 1'b0, lsqCountT'(k + 1));
      addRow(OP_AGEN_LD, 1'b0, lsqIdT'(5 + k), missAddrs[k], missData[k], 1'b0, 4'd0);
    end
  endfunction

  task automatic dispatchOp(input opRowT op);
    @(negedge clk);
    dispatchIsStore = op.isStore;  // ready and id follow the target queue
    @(negedge clk);
    while (!dispatchReady)
    begin
      @(negedge clk);
    end
    checkId("dispatch id", dispatchId, op.id);
    dispatchValid = 1'b1;
    @(negedge clk);
    dispatchValid = 1'b0;
    if (op.isStore)
    begin
      checkCount("store queue count", stqCount, op.cnt);
    end
    else
    begin
      checkCount("load queue count", ldqCount, op.cnt);
    end
  endtask

  task automatic fullCheckOp(input opRowT op);
    @(negedge clk);
    dispatchIsStore = 1'b1;
    @(negedge clk);
    checkFlag("dispatch ready with store queue full", dispatchReady, 1'b0);
    checkCount("store queue count", stqCount, op.cnt);
  endtask

  task automatic agenOp(input opRowT op);
    @(negedge clk);
    while (!agenReady)
    begin
      @(negedge clk);
    end
    agenValid   = 1'b1;
    agenIsStore = (op.kind == OP_AGEN_ST);
    agenId      = op.id;
    agenAddr    = op.addr;
    agenData    = (op.kind == OP_AGEN_ST) ? op.data : '0;
    @(negedge clk);
    agenValid = 1'b0;
    if (op.kind == OP_AGEN_LD)
    begin
      checkFlag("agen ready while load in flight", agenReady, 1'b0);
      if (op.fwd)
      begin
        checkFlag("writeback in cycle after forwarding hit", wbValid, 1'b1);
      end
      while (!wbValid)
      begin
        @(negedge clk);
      end
      checkId("writeback id", wbId, op.id);
      checkData("writeback data", wbData, op.data);
      checkFlag("writeback forwarded", wbForwarded, op.fwd);
      @(negedge clk);
      checkFlag("writeback valid one cycle later", wbValid, 1'b0);  // single-cycle pulse
      while (!agenReady)
      begin
        @(negedge clk);  // back-pressure must clear
      end
    end
  endtask

  task automatic commitLoadOp(input opRowT op);
    @(negedge clk);
    commitLoad = 1'b1;
    @(negedge clk);
    commitLoad = 1'b0;
    checkCount("load queue count", ldqCount, op.cnt);
  endtask

  task automatic commitStoreOp(input opRowT op);
    @(negedge clk);
    while (!stCommitReady)
    begin
      @(negedge clk);
    end
    commitStore = 1'b1;
    @(negedge clk);
    commitStore = 1'b0;
    checkFlag("store commit ready during write", stCommitReady, 1'b0);
    while (!stCommitReady)
    begin
      @(negedge clk);  // head freed when ack falls
    end
    checkCount("store queue count", stqCount, op.cnt);
  endtask

  task automatic runOp(input opRowT op);
    case (op.kind)
      OP_DISPATCH:  dispatchOp(op);
      OP_FULL:      fullCheckOp(op);
      OP_AGEN_ST,
      OP_AGEN_LD:   agenOp(op);
      OP_COMMIT_LD: commitLoadOp(op);
      default:      commitStoreOp(op);
    endcase
  endtask

  initial
  begin
    reset           = 1'b1;
    dispatchValid   = 1'b0;
    dispatchIsStore = 1'b0;
    agenValid       = 1'b0;
    agenIsStore     = 1'b0;
    agenId          = '0;
    agenAddr        = '0;
    agenData        = '0;
    commitLoad      = 1'b0;
    commitStore     = 1'b0;
    buildTable();
    cycleLimit = 40 * opTable.size() + 100;
    repeat (2) @(posedge clk);  // two reset cycles
    @(negedge clk);
    reset = 1'b0;
    // idle state out of reset
    checkFlag("ldReq after reset", ldReq, 1'b0);
    checkFlag("stReq after reset", stReq, 1'b0);
    checkFlag("wbValid after reset", wbValid, 1'b0);
    checkCount("load queue count after reset", ldqCount, 4'd0);
    checkCount("store queue count after reset", stqCount, 4'd0);
    checkFlag("dispatch ready after reset", dispatchReady, 1'b1);
    checkFlag("agen ready after reset", agenReady, 1'b1);
    checkFlag("store commit ready after reset", stCommitReady, 1'b1);
    foreach (opTable[i])
    begin
      runOp(opTable[i]);
    end
    $display("All tests passed");
    $finish;
  end

endmodule

//--- all.f
hdl/lsqPkg.sv
hdl/memPkg.sv
hdl/lsqAlloc.sv
hdl/storeQueue.sv
hdl/loadExecute.sv
hdl/storeCommit.sv
hdl/lsuTop.sv
tests/memResponder.sv
tests/lsuTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module lsuTb -f all.f -o lsuSim
	./obj_dir/lsuSim

clean:
	rm -rf obj_dir
